// File: common/fabric_pkg.sv
`default_nettype none

// ============================================================
// Fabric side types
// ============================================================
package fabric_pkg;

    // Fabric request opcode
    // Reads return the stored word, writes store a full word
    typedef enum logic {
        RD_REQ = 1'b0,  // Read one word
        WR_REQ = 1'b1   // Write one full word
    } t_fab_op;

endpackage

`default_nettype wire

// File: common/mem_map_pkg.sv
`default_nettype none

`include "mem_params.svh"

// ============================================================
// Memory map types
// ============================================================
package mem_map_pkg;

    // Region index
    // Also the generate index and hit vector bit
    typedef enum logic {
        I_MEM = 1'b0,   // Instruction memory
        D_MEM = 1'b1    // Data memory
    } t_mem_region;

    // One hit bit per region, indexed by t_mem_region
    typedef logic [`NUM_MEM_REGIONS-1:0] t_region_hits;

endpackage

`default_nettype wire

// File: common/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ============================================================
// Word geometry
// ============================================================
`define MEM_WORD_WIDTH      32      // Data word, bits
`define MEM_BYTES           4       // Byte lanes per word

// Word index per region, 4096 words
// Taken from address bits 13:2
`define MEM_ADRS_WIDTH      12

// ============================================================
// Memory map
// ============================================================
`define REGION_MSB          31      // Region field, top bit
`define REGION_LSB          16      // Region field, bottom bit

// Hit means floor < field < roof, strictly on both sides
`define I_MEM_REGION_FLOOR  0
`define I_MEM_REGION_ROOF   2       // I_MEM at field 1
`define D_MEM_REGION_FLOOR  1
`define D_MEM_REGION_ROOF   3       // D_MEM at field 2

`define NUM_MEM_REGIONS     2       // I_MEM and D_MEM

`endif

// File: common/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// One port of a dual-port memory
// No handshake, write at the edge where wr_en is high
// rd_data follows the address by one cycle
interface mem_port_if;

    logic [`MEM_ADRS_WIDTH-1:0] address;    // Word index
    logic [`MEM_WORD_WIDTH-1:0] wr_data;
    logic [`MEM_BYTES-1:0]      byte_en;    // One bit per byte lane
    logic                       wr_en;
    logic [`MEM_WORD_WIDTH-1:0] rd_data;    // Registered, read-first

    // Requester side
    modport master (
        output address,
        output wr_data,
        output byte_en,
        output wr_en,
        input  rd_data
    );

    // Storage side
    modport memory (
        input  address,
        input  wr_data,
        input  byte_en,
        input  wr_en,
        output rd_data
    );

endinterface

`default_nettype wire

// File: dp_mem/dp_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Dual-port synchronous memory
// Read-first on both ports, byte enables on both ports
// Same word written on both ports at one edge leaves port b data
module dp_mem (
    input  wire logic  clock,
    mem_port_if.memory port_a,      // Core side
    mem_port_if.memory port_b       // Fabric side
);

    localparam int DEPTH  = 2 ** `MEM_ADRS_WIDTH;
    localparam int BYTE_W = `MEM_WORD_WIDTH / `MEM_BYTES;

    logic [`MEM_WORD_WIDTH-1:0] mem [DEPTH];   // Storage, contents not reset

    // ============================================================
    // Read and write, one edge
    // ============================================================
    always_ff @(posedge clock) begin
        // Old word on both ports
        port_a.rd_data <= mem[port_a.address];
        port_b.rd_data <= mem[port_b.address];

        // Port a bytes first
        if (port_a.wr_en) begin
            for (int i = 0; i < `MEM_BYTES; i++) begin
                if (port_a.byte_en[i]) begin
                    mem[port_a.address][i*BYTE_W +: BYTE_W] <=
                        port_a.wr_data[i*BYTE_W +: BYTE_W];
                end
            end
        end

        // Port b last so it wins a collision
        if (port_b.wr_en) begin
            for (int i = 0; i < `MEM_BYTES; i++) begin
                if (port_b.byte_en[i]) begin
                    mem[port_b.address][i*BYTE_W +: BYTE_W] <=
                        port_b.wr_data[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fabric_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Fabric request decoder
// Turns one fabric request into a hit vector and a port b drive per region
module fabric_decode (
    input  wire logic                       req_valid,
    input  wire fabric_pkg::t_fab_op        req_opcode,
    input  wire logic [31:0]                req_address,
    input  wire logic [`MEM_WORD_WIDTH-1:0] req_data,
    output mem_map_pkg::t_region_hits       hits,
    mem_port_if.master                      fab_port [`NUM_MEM_REGIONS]
);

    import fabric_pkg::*;
    import mem_map_pkg::*;

    localparam int REGION_WIDTH = `REGION_MSB - `REGION_LSB + 1;
    localparam int BYTE_OFFSET  = $clog2(`MEM_BYTES);    // Word aligned index

    logic [REGION_WIDTH-1:0]    region_field;
    logic [`MEM_ADRS_WIDTH-1:0] word_index;
    logic                       wr_req;                  // Valid write, any region

    assign region_field = req_address[`REGION_MSB:`REGION_LSB];
    assign word_index   = req_address[`MEM_ADRS_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];
    assign wr_req       = req_valid && (req_opcode == WR_REQ);

    // ============================================================
    // Per region compare and port b drive
    // ============================================================
    for (genvar r = 0; r < `NUM_MEM_REGIONS; r++) begin : g_region
        localparam t_mem_region REGION = t_mem_region'(r);

        // Bounds for this region
        localparam int FLOOR = (REGION == I_MEM) ? `I_MEM_REGION_FLOOR
                                                 : `D_MEM_REGION_FLOOR;
        localparam int ROOF  = (REGION == I_MEM) ? `I_MEM_REGION_ROOF
                                                 : `D_MEM_REGION_ROOF;

        // Strict compare on both sides
        assign hits[r] = (int'(region_field) > FLOOR) && (int'(region_field) < ROOF);

        // Address and data go to every region, only the hit one writes
        assign fab_port[r].address = word_index;
        assign fab_port[r].wr_data = req_data;
        assign fab_port[r].byte_en = '1;                 // Fabric writes full words
        assign fab_port[r].wr_en   = wr_req && hits[r];
    end

endmodule

`default_nettype wire

// File: hdl/fabric_rsp_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Fabric response path
// Hit flags travel with the request, so the select matches the read
module fabric_rsp_mux (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       req_valid,
    input  wire mem_map_pkg::t_region_hits  hits,
    input  wire logic [`MEM_WORD_WIDTH-1:0] fab_rd_data [`NUM_MEM_REGIONS],
    output logic                            rsp_valid,
    output logic [`MEM_WORD_WIDTH-1:0]      rsp_data
);

    import mem_map_pkg::*;

    t_region_hits hits_q;   // Hits of the request in flight

    // ============================================================
    // Request stage register
    // ============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_valid <= 1'b0;
            hits_q    <= '0;
        end else begin
            rsp_valid <= req_valid;                  // Always one cycle later
            hits_q    <= req_valid ? hits : '0;      // Idle cycle selects nothing
        end
    end

    // Priority select, I_MEM first
    always_comb begin
        if (hits_q[I_MEM]) begin
            rsp_data = fab_rd_data[I_MEM];
        end else if (hits_q[D_MEM]) begin
            rsp_data = fab_rd_data[D_MEM];
        end else begin
            rsp_data = '0;                           // Unmapped or idle
        end
    end

endmodule

`default_nettype wire

// File: hdl/mini_mem_wrap.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

// Memory wrapper of the mini core
// Port a of each region faces the core, port b faces the fabric
module mini_mem_wrap (
    input  wire logic                       clock,
    input  wire logic                       reset,

    // ============================================================
    // Core side, instruction fetch
    // ============================================================
    input  wire logic [31:0]                pc,
    output logic [`MEM_WORD_WIDTH-1:0]      instruction,      // One cycle after pc

    // ============================================================
    // Core side, data access
    // ============================================================
    input  wire logic [31:0]                dmem_address,
    input  wire logic [`MEM_WORD_WIDTH-1:0] dmem_wr_data,
    input  wire logic [`MEM_BYTES-1:0]      dmem_byte_en,
    input  wire logic                       dmem_wr_en,
    output logic [`MEM_WORD_WIDTH-1:0]      dmem_rd_data,     // Old word, read-first

    // ============================================================
    // Fabric side
    // ============================================================
    input  wire logic                       f2c_req_valid,
    input  wire fabric_pkg::t_fab_op        f2c_req_opcode,
    input  wire logic [31:0]                f2c_req_address,
    input  wire logic [`MEM_WORD_WIDTH-1:0] f2c_req_data,
    output logic                            f2c_rsp_valid,
    output logic [`MEM_WORD_WIDTH-1:0]      f2c_rsp_data
);

    import mem_map_pkg::*;

    localparam int BYTE_OFFSET = $clog2(`MEM_BYTES);

    // Port a and port b of every region
    mem_port_if core_port [`NUM_MEM_REGIONS] ();
    mem_port_if fab_port  [`NUM_MEM_REGIONS] ();

    t_region_hits               f2c_hits;                      // Request cycle hits
    logic [`MEM_WORD_WIDTH-1:0] fab_rd_data [`NUM_MEM_REGIONS];

    // ============================================================
    // Core port a mapping
    // ============================================================
    // Fetch is read only
    assign core_port[I_MEM].address = pc[`MEM_ADRS_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];
    assign core_port[I_MEM].wr_data = '0;
    assign core_port[I_MEM].byte_en = '0;
    assign core_port[I_MEM].wr_en   = 1'b0;
    assign instruction              = core_port[I_MEM].rd_data;

    // Data port straight from the core
    assign core_port[D_MEM].address =
        dmem_address[`MEM_ADRS_WIDTH+BYTE_OFFSET-1:BYTE_OFFSET];
    assign core_port[D_MEM].wr_data = dmem_wr_data;
    assign core_port[D_MEM].byte_en = dmem_byte_en;     // Partial writes allowed
    assign core_port[D_MEM].wr_en   = dmem_wr_en;
    assign dmem_rd_data             = core_port[D_MEM].rd_data;

    // ============================================================
    // Fabric request decode
    // ============================================================
    fabric_decode u_decode (
        .req_valid   (f2c_req_valid),
        .req_opcode  (f2c_req_opcode),
        .req_address (f2c_req_address),
        .req_data    (f2c_req_data),
        .hits        (f2c_hits),
        .fab_port    (fab_port)
    );

    // ============================================================
    // Memory array, one dp_mem per region
    // ============================================================
    for (genvar r = 0; r < `NUM_MEM_REGIONS; r++) begin : g_region
        dp_mem u_mem (
            .clock  (clock),
            .port_a (core_port[r].memory),
            .port_b (fab_port[r].memory)
        );

        // Port b read data out to the response mux
        assign fab_rd_data[r] = fab_port[r].rd_data;
    end

    // ============================================================
    // Fabric response
    // ============================================================
    fabric_rsp_mux u_rsp_mux (
        .clock       (clock),
        .reset       (reset),
        .req_valid   (f2c_req_valid),
        .hits        (f2c_hits),
        .fab_rd_data (fab_rd_data),
        .rsp_valid   (f2c_rsp_valid),
        .rsp_data    (f2c_rsp_data)
    );

endmodule

`default_nettype wire

// File: mini_mem_wrap.f
+incdir+common
common/fabric_pkg.sv
common/mem_map_pkg.sv
common/mem_port_if.sv
dp_mem/dp_mem.sv
hdl/fabric_decode.sv
hdl/fabric_rsp_mux.sv
hdl/mini_mem_wrap.sv
tests/mini_mem_wrap_tb.sv

// File: tests/mini_mem_wrap_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the mini core memory wrapper
// Random traffic on the core and fabric ports, checked against a word model
module mini_mem_wrap_tb;

    import fabric_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int TEST_WORDS  = 64;        // First words of each region only
    localparam int NUM_FETCH   = 200;
    localparam int NUM_DATA    = 300;
    localparam int NUM_FAB     = 300;
    localparam int NUM_COLLIDE = 20;
    localparam int NUM_TXNS    = 2 * TEST_WORDS + NUM_FETCH + NUM_DATA + NUM_FAB
                                 + 2 * NUM_COLLIDE + 20;    // Reset and idle gaps
    localparam int TIMEOUT_NS  = (NUM_TXNS + 200) * CLK_PERIOD;

    localparam int          REG_I   = 0;
    localparam int          REG_D   = 1;
    localparam logic [15:0] I_FIELD = 16'h0001;     // Instruction region
    localparam logic [15:0] D_FIELD = 16'h0002;     // Data region

    logic        clock;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic [31:0] dmem_address;
    logic [31:0] dmem_wr_data;
    logic [3:0]  dmem_byte_en;
    logic        dmem_wr_en;
    logic [31:0] dmem_rd_data;
    logic        f2c_req_valid;
    t_fab_op     f2c_req_opcode;
    logic [31:0] f2c_req_address;
    logic [31:0] f2c_req_data;
    logic        f2c_rsp_valid;
    logic [31:0] f2c_rsp_data;

    integer      seed;
    logic [31:0] imem_model [int];          // Word index to word
    logic [31:0] dmem_model [int];

    mini_mem_wrap u_dut (
        .clock           (clock),
        .reset           (reset),
        .pc              (pc),
        .instruction     (instruction),
        .dmem_address    (dmem_address),
        .dmem_wr_data    (dmem_wr_data),
        .dmem_byte_en    (dmem_byte_en),
        .dmem_wr_en      (dmem_wr_en),
        .dmem_rd_data    (dmem_rd_data),
        .f2c_req_valid   (f2c_req_valid),
        .f2c_req_opcode  (f2c_req_opcode),
        .f2c_req_address (f2c_req_address),
        .f2c_req_data    (f2c_req_data),
        .f2c_rsp_valid   (f2c_rsp_valid),
        .f2c_rsp_data    (f2c_rsp_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Watchdog, sized from the transaction count
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test sequence did not complete in time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

    // ============================================================
    // Model helpers
    // ============================================================
    function automatic logic [31:0] make_addr(input logic [15:0] field, input int idx);
        return {field, 16'h0000} | (idx << 2);      // Byte address of a word
    endfunction

    function automatic int word_of(input logic [31:0] addr);
        return int'(addr[13:2]);
    endfunction

    // Region field 1 is instruction, 2 is data, rest unmapped
    function automatic int region_of(input logic [31:0] addr);
        case (addr[31:16])
            16'h0001: return REG_I;
            16'h0002: return REG_D;
            default:  return -1;
        endcase
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic bit model_has(input int region, input int idx);
        if (region == REG_I) return imem_model.exists(idx) != 0;
        return dmem_model.exists(idx) != 0;
    endfunction

    function automatic logic [31:0] model_read(input int region, input int idx);
        if (region == REG_I) return imem_model[idx];
        return dmem_model[idx];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // ============================================================
    // One clock edge: predict, update model, advance, compare
    // ============================================================
    task automatic apply_cycle(input bit chk_fetch, input bit chk_data);
        logic        exp_valid;
        logic [31:0] exp_rsp;
        logic [31:0] exp_instr;
        logic [31:0] exp_dmem;
        bit          chk_rsp;
        bit          fab_wr;
        int          fr;
        int          fi;
        int          ci;
        fr        = region_of(f2c_req_address);
        fi        = word_of(f2c_req_address);
        ci        = word_of(dmem_address);
        exp_valid = f2c_req_valid;
        exp_rsp   = '0;                                 // Idle or unmapped
        chk_rsp   = 1'b1;
        fab_wr    = f2c_req_valid && f2c_req_opcode == WR_REQ;
        if (f2c_req_valid && fr >= 0) begin
            if (model_has(fr, fi)) exp_rsp = model_read(fr, fi);
            else chk_rsp = 1'b0;                        // Word never written yet
        end
        exp_instr = model_read(REG_I, word_of(pc));     // Read-first, before writes
        exp_dmem  = model_read(REG_D, ci);
        // Core write first
        if (dmem_wr_en) begin
            dmem_model[ci] = merge_bytes(dmem_model[ci], dmem_wr_data, dmem_byte_en);
        end
        // Fabric write last, so it wins a collision
        if (fab_wr && fr == REG_I) imem_model[fi] = f2c_req_data;
        if (fab_wr && fr == REG_D) dmem_model[fi] = f2c_req_data;
        @(posedge clock);
        #1;
        check_value("f2c_rsp_valid", {31'b0, exp_valid}, {31'b0, f2c_rsp_valid});
        if (chk_rsp) check_value("f2c_rsp_data", exp_rsp, f2c_rsp_data);
        if (chk_fetch) check_value("instruction", exp_instr, instruction);
        if (chk_data) check_value("dmem_rd_data", exp_dmem, dmem_rd_data);
    endtask

    task automatic drive_idle(input int cycles);
        f2c_req_valid   = 1'b0;
        f2c_req_opcode  = RD_REQ;
        f2c_req_address = '0;
        f2c_req_data    = '0;
        dmem_wr_en      = 1'b0;
        dmem_byte_en    = '0;
        repeat (cycles) apply_cycle(1'b0, 1'b0);
    endtask

    task automatic drive_fabric(input t_fab_op op, input logic [31:0] addr,
                                input logic [31:0] data);
        f2c_req_valid   = 1'b1;
        f2c_req_opcode  = op;
        f2c_req_address = addr;
        f2c_req_data    = data;
    endtask

    // ============================================================
    // Test phases
    // ============================================================
    task automatic preload_regions();
        for (int i = 0; i < 2 * TEST_WORDS; i++) begin
            drive_fabric(WR_REQ, make_addr(i < TEST_WORDS ? I_FIELD : D_FIELD, i % TEST_WORDS),
                         $random(seed));
            apply_cycle(1'b0, 1'b0);
        end
        drive_idle(3);
    endtask

    task automatic fetch_test();
        for (int i = 0; i < NUM_FETCH; i++) begin
            pc = make_addr(I_FIELD, $random(seed) & (TEST_WORDS - 1));
            apply_cycle(1'b1, 1'b0);
        end
        drive_idle(2);
    endtask

    task automatic core_data_test();
        for (int i = 0; i < NUM_DATA; i++) begin
            dmem_address = make_addr(D_FIELD, $random(seed) & (TEST_WORDS - 1));
            dmem_wr_data = $random(seed);
            dmem_byte_en = $random(seed);
            dmem_wr_en   = $random(seed) & 1;           // About half writes
            apply_cycle(1'b0, 1'b1);
        end
        drive_idle(2);
    endtask

    task automatic fabric_test();
        logic [15:0] field;
        int          sel;
        for (int i = 0; i < NUM_FAB; i++) begin
            sel = $random(seed) & 3;
            case (sel)
                0:       field = I_FIELD;
                1:       field = D_FIELD;
                2:       field = 16'h0000;                      // Below both regions
                default: field = 16'h0003 + ($random(seed) & 16'h0fff);
            endcase
            drive_fabric(($random(seed) & 1) ? WR_REQ : RD_REQ,
                         make_addr(field, $random(seed) & (TEST_WORDS - 1)), $random(seed));
            apply_cycle(1'b0, 1'b0);
        end
        drive_idle(2);
    endtask

    task automatic collision_test();
        int idx;
        for (int i = 0; i < NUM_COLLIDE; i++) begin
            idx          = $random(seed) & (TEST_WORDS - 1);
            dmem_address = make_addr(D_FIELD, idx);
            dmem_wr_data = $random(seed);
            dmem_byte_en = 4'hf;
            dmem_wr_en   = 1'b1;
            drive_fabric(WR_REQ, make_addr(D_FIELD, idx), $random(seed));
            apply_cycle(1'b0, 1'b1);
            drive_idle(0);
            apply_cycle(1'b0, 1'b1);                    // Read back, fabric word expected
        end
        drive_idle(2);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        seed            = 32'hd551_a19e;
        reset           = 1'b1;
        pc              = make_addr(I_FIELD, 0);
        dmem_address    = make_addr(D_FIELD, 0);
        dmem_wr_data    = '0;
        dmem_byte_en    = '0;
        dmem_wr_en      = 1'b0;
        f2c_req_valid   = 1'b1;                 // Read held through reset, no response due
        f2c_req_opcode  = RD_REQ;
        f2c_req_address = make_addr(I_FIELD, 0);
        f2c_req_data    = '0;

        repeat (3) @(posedge clock);
        #1;
        reset           = 1'b0;
        f2c_req_valid   = 1'b0;
        f2c_req_address = '0;
        check_value("f2c_rsp_valid", 32'h0, {31'b0, f2c_rsp_valid});   // Low out of reset
        check_value("f2c_rsp_data", 32'h0, f2c_rsp_data);              // Hits cleared

        preload_regions();
        fetch_test();
        core_data_test();
        fabric_test();
        collision_test();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
